// File: hdl/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath and register file sizes
`define CPU_XLEN      32
`define CPU_REG_AW    5
`define CPU_REG_NUM   32
`define CPU_RESET_PC  32'h1bfff_ffc
`define CPU_LINK_REG  5'd1

// 3R group, inst[31:20], minor opcode in inst[19:15]
`define CPU_OP_3R     12'h001
`define CPU_OP_ADD_W  5'h00
`define CPU_OP_SUB_W  5'h02
`define CPU_OP_SLT    5'h04
`define CPU_OP_SLTU   5'h05
`define CPU_OP_NOR    5'h08
`define CPU_OP_AND    5'h09
`define CPU_OP_OR     5'h0a
`define CPU_OP_XOR    5'h0b

// 2RI12 forms, inst[31:22]
`define CPU_OP_ADDI_W 10'h00a
`define CPU_OP_LD_W   10'h0a2
`define CPU_OP_ST_W   10'h0a6

// lu12i.w uses inst[31:25], branches inst[31:26]
`define CPU_OP_LU12I  7'h0a
`define CPU_OP_B      6'h14
`define CPU_OP_BL     6'h15
`define CPU_OP_BEQ    6'h16
`define CPU_OP_BNE    6'h17

`endif

// File: hdl/cpu_pkg.sv
`include "cpu_macros.svh"

package cpu_pkg;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_nor,
        alu_xor,
        alu_lui
    } alu_op_e;

    // operand source chosen in decode
    typedef enum logic [1:0] {
        fwd_from_rf,
        fwd_from_exe,
        fwd_from_mem,
        fwd_from_wb
    } fwd_sel_e;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] inst;
    } if_id_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]   pc;
        alu_op_e                alu_op;
        logic [`CPU_XLEN-1:0]   src1;
        logic [`CPU_XLEN-1:0]   src2;
        logic [`CPU_XLEN-1:0]   store_data;
        logic [`CPU_REG_AW-1:0] dest;
        logic                   gr_we;
        logic                   mem_we;
        logic                   is_load;
    } id_exe_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]   pc;
        logic [`CPU_XLEN-1:0]   result;
        logic [`CPU_REG_AW-1:0] dest;
        logic                   gr_we;
        logic                   is_load;
    } exe_mem_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]   pc;
        logic [`CPU_XLEN-1:0]   wdata;
        logic [`CPU_REG_AW-1:0] dest;
        logic                   gr_we;
    } mem_wb_t;

    // what a later stage will write, for hazard checks
    typedef struct packed {
        logic                   valid;
        logic                   gr_we;
        logic                   is_load;
        logic [`CPU_REG_AW-1:0] dest;
        logic [`CPU_XLEN-1:0]   fwd_data;
    } stage_dest_t;

    typedef struct packed {
        logic                 en;
        logic [`CPU_XLEN-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic                 en;
        logic [3:0]           we;
        logic [`CPU_XLEN-1:0] addr;
        logic [`CPU_XLEN-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0]   pc;
        logic [3:0]             rf_we;
        logic [`CPU_REG_AW-1:0] wnum;
        logic [`CPU_XLEN-1:0]   wdata;
    } trace_t;

endpackage

// File: hdl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     allowin,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (allowin) begin
            out_valid <= in_valid;
        end else if (flush) begin
            out_valid <= 1'b0;
        end
    end

    // payload only moves with a valid entry
    always_ff @(posedge clk) begin
        if (allowin && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_unit
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 br_taken,
    input  logic [`CPU_XLEN-1:0] br_target,
    output imem_req_t            imem,
    input  logic [`CPU_XLEN-1:0] imem_rdata,
    output logic                 to_id_valid,
    output if_id_t               to_id
);

    // pc of the word now on imem_rdata
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] next_pc;
    logic                 if_valid;

    assign next_pc = br_taken ? br_target : pc + 'd4;

    // a taken branch always redirects, even over a stall
    assign imem.en   = br_taken | ~stall;
    assign imem.addr = next_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc       <= `CPU_RESET_PC;
            if_valid <= 1'b0;
        end else if (imem.en) begin
            pc       <= next_pc;
            if_valid <= 1'b1;
        end
    end

    // squash the sequential word behind a taken branch
    assign to_id_valid = if_valid & ~br_taken;
    assign to_id.pc    = pc;
    assign to_id.inst  = imem_rdata;

endmodule

// File: hdl/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decode_unit
    import cpu_pkg::*;
(
    input  logic                   id_valid,
    input  if_id_t                 id,
    output logic [`CPU_REG_AW-1:0] rf_raddr1,
    output logic [`CPU_REG_AW-1:0] rf_raddr2,
    input  logic [`CPU_XLEN-1:0]   rf_rdata1,
    input  logic [`CPU_XLEN-1:0]   rf_rdata2,
    output logic                   src1_used,
    output logic                   src2_used,
    input  fwd_sel_e               fwd1,
    input  fwd_sel_e               fwd2,
    input  logic [`CPU_XLEN-1:0]   fwd_exe,
    input  logic [`CPU_XLEN-1:0]   fwd_mem,
    input  logic [`CPU_XLEN-1:0]   fwd_wb,
    input  logic                   stall,
    output logic                   br_taken,
    output logic [`CPU_XLEN-1:0]   br_target,
    output id_exe_t                to_exe
);

    logic [`CPU_XLEN-1:0] inst;
    logic                 is_3r;
    logic [4:0]           minor;
    logic                 inst_addi, inst_ld, inst_st, inst_lu12i;
    logic                 inst_b, inst_bl, inst_beq, inst_bne;
    logic [`CPU_XLEN-1:0] si12, si20, offs16, offs26;
    logic [`CPU_XLEN-1:0] rj_value, rkd_value;
    alu_op_e              alu_op;

    assign inst  = id.inst;
    assign is_3r = inst[31:20] == `CPU_OP_3R;
    assign minor = inst[19:15];

    assign inst_addi  = inst[31:22] == `CPU_OP_ADDI_W;
    assign inst_ld    = inst[31:22] == `CPU_OP_LD_W;
    assign inst_st    = inst[31:22] == `CPU_OP_ST_W;
    assign inst_lu12i = inst[31:25] == `CPU_OP_LU12I;
    assign inst_b     = inst[31:26] == `CPU_OP_B;
    assign inst_bl    = inst[31:26] == `CPU_OP_BL;
    assign inst_beq   = inst[31:26] == `CPU_OP_BEQ;
    assign inst_bne   = inst[31:26] == `CPU_OP_BNE;

    // immediates and branch offsets
    assign si12   = {{20{inst[21]}}, inst[21:10]};
    assign si20   = {inst[24:5], 12'b0};
    assign offs16 = {{14{inst[25]}}, inst[25:10], 2'b0};
    assign offs26 = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};

    // stores and compares read rd on the second port
    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = (inst_st | inst_beq | inst_bne) ? inst[4:0] : inst[14:10];
    assign src1_used = is_3r | inst_addi | inst_ld | inst_st | inst_beq | inst_bne;
    assign src2_used = is_3r | inst_st | inst_beq | inst_bne;

    assign rj_value  = fwd1 == fwd_from_exe ? fwd_exe :
                       fwd1 == fwd_from_mem ? fwd_mem :
                       fwd1 == fwd_from_wb  ? fwd_wb  : rf_rdata1;
    assign rkd_value = fwd2 == fwd_from_exe ? fwd_exe :
                       fwd2 == fwd_from_mem ? fwd_mem :
                       fwd2 == fwd_from_wb  ? fwd_wb  : rf_rdata2;

    always_comb begin
        alu_op = alu_add;
        if (inst_lu12i) begin
            alu_op = alu_lui;
        end else if (is_3r) begin
            case (minor)
                `CPU_OP_SUB_W: alu_op = alu_sub;
                `CPU_OP_SLT:   alu_op = alu_slt;
                `CPU_OP_SLTU:  alu_op = alu_sltu;
                `CPU_OP_NOR:   alu_op = alu_nor;
                `CPU_OP_AND:   alu_op = alu_and;
                `CPU_OP_OR:    alu_op = alu_or;
                `CPU_OP_XOR:   alu_op = alu_xor;
                default:       alu_op = alu_add;
            endcase
        end
    end

    // resolved here so only the word in fetch is lost
    assign br_taken  = id_valid & ~stall & (inst_b | inst_bl |
                       (inst_beq & (rj_value == rkd_value)) |
                       (inst_bne & (rj_value != rkd_value)));
    assign br_target = id.pc + ((inst_b | inst_bl) ? offs26 : offs16);

    assign to_exe.pc         = id.pc;
    assign to_exe.alu_op     = alu_op;
    assign to_exe.src1       = inst_bl ? id.pc : rj_value;
    assign to_exe.src2       = inst_bl ? 'd4 :
                               (inst_addi | inst_ld | inst_st) ? si12 :
                               inst_lu12i ? si20 : rkd_value;
    assign to_exe.store_data = rkd_value;
    assign to_exe.dest       = inst_bl ? `CPU_LINK_REG : inst[4:0];
    assign to_exe.gr_we      = is_3r | inst_addi | inst_lu12i | inst_ld | inst_bl;
    assign to_exe.mem_we     = inst_st;
    assign to_exe.is_load    = inst_ld;

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_file (
    input  logic                   clk,
    input  logic [`CPU_REG_AW-1:0] raddr1,
    input  logic [`CPU_REG_AW-1:0] raddr2,
    output logic [`CPU_XLEN-1:0]   rdata1,
    output logic [`CPU_XLEN-1:0]   rdata2,
    input  logic                   we,
    input  logic [`CPU_REG_AW-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]   wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_NUM];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module hazard_unit
    import cpu_pkg::*;
(
    input  logic                   id_valid,
    input  logic [`CPU_REG_AW-1:0] rs1,
    input  logic [`CPU_REG_AW-1:0] rs2,
    input  logic                   src1_used,
    input  logic                   src2_used,
    input  stage_dest_t            exe_dst,
    input  stage_dest_t            mem_dst,
    input  stage_dest_t            wb_dst,
    output fwd_sel_e               fwd1,
    output fwd_sel_e               fwd2,
    output logic                   stall
);

    logic hit_exe1, hit_mem1, hit_wb1;
    logic hit_exe2, hit_mem2, hit_wb2;

    // r0 never forwards, it always reads zero
    function automatic logic hit(input stage_dest_t d, input logic [`CPU_REG_AW-1:0] rs,
                                 input logic used);
        return used & d.valid & d.gr_we & (d.dest == rs) & (rs != '0);
    endfunction

    assign hit_exe1 = hit(exe_dst, rs1, src1_used);
    assign hit_mem1 = hit(mem_dst, rs1, src1_used);
    assign hit_wb1  = hit(wb_dst, rs1, src1_used);
    assign hit_exe2 = hit(exe_dst, rs2, src2_used);
    assign hit_mem2 = hit(mem_dst, rs2, src2_used);
    assign hit_wb2  = hit(wb_dst, rs2, src2_used);

    // youngest producer wins
    assign fwd1 = hit_exe1 ? fwd_from_exe :
                  hit_mem1 ? fwd_from_mem :
                  hit_wb1  ? fwd_from_wb  : fwd_from_rf;
    assign fwd2 = hit_exe2 ? fwd_from_exe :
                  hit_mem2 ? fwd_from_mem :
                  hit_wb2  ? fwd_from_wb  : fwd_from_rf;

    // load data only exists once the load reaches memory
    assign stall = id_valid & exe_dst.is_load & (hit_exe1 | hit_exe2);

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module execute_unit
    import cpu_pkg::*;
(
    input  logic        exe_valid,
    input  id_exe_t     exe,
    output dmem_req_t   dmem,
    output exe_mem_t    to_mem,
    output stage_dest_t exe_dst
);

    logic [`CPU_XLEN-1:0] result;

    always_comb begin
        case (exe.alu_op)
            alu_add:  result = exe.src1 + exe.src2;
            alu_sub:  result = exe.src1 - exe.src2;
            alu_slt:  result = {31'b0, $signed(exe.src1) < $signed(exe.src2)};
            alu_sltu: result = {31'b0, exe.src1 < exe.src2};
            alu_and:  result = exe.src1 & exe.src2;
            alu_or:   result = exe.src1 | exe.src2;
            alu_nor:  result = ~(exe.src1 | exe.src2);
            alu_xor:  result = exe.src1 ^ exe.src2;
            // immediate already shifted in decode
            alu_lui:  result = exe.src2;
            default:  result = '0;
        endcase
    end

    // word access only, address comes straight from the adder
    assign dmem.en    = exe_valid & (exe.is_load | exe.mem_we);
    assign dmem.we    = {4{exe_valid & exe.mem_we}};
    assign dmem.addr  = result;
    assign dmem.wdata = exe.store_data;

    assign to_mem.pc      = exe.pc;
    assign to_mem.result  = result;
    assign to_mem.dest    = exe.dest;
    assign to_mem.gr_we   = exe.gr_we;
    assign to_mem.is_load = exe.is_load;

    // for a load this value is not usable yet, hazard unit stalls
    assign exe_dst.valid    = exe_valid;
    assign exe_dst.gr_we    = exe.gr_we;
    assign exe_dst.is_load  = exe.is_load;
    assign exe_dst.dest     = exe.dest;
    assign exe_dst.fwd_data = result;

endmodule

// File: hdl/writeback_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module writeback_unit
    import cpu_pkg::*;
(
    input  logic                   mem_valid,
    input  exe_mem_t               mem,
    input  logic [`CPU_XLEN-1:0]   dmem_rdata,
    output mem_wb_t                to_wb,
    output stage_dest_t            mem_dst,
    input  logic                   wb_valid,
    input  mem_wb_t                wb,
    output logic                   rf_we,
    output logic [`CPU_REG_AW-1:0] rf_waddr,
    output logic [`CPU_XLEN-1:0]   rf_wdata,
    output stage_dest_t            wb_dst,
    output trace_t                 trace
);

    logic [`CPU_XLEN-1:0] final_result;

    // memory stage, load data arrives this cycle
    assign final_result = mem.is_load ? dmem_rdata : mem.result;

    assign to_wb.pc    = mem.pc;
    assign to_wb.wdata = final_result;
    assign to_wb.dest  = mem.dest;
    assign to_wb.gr_we = mem.gr_we;

    assign mem_dst = '{valid: mem_valid, gr_we: mem.gr_we, is_load: mem.is_load,
                       dest: mem.dest, fwd_data: final_result};

    // writeback stage
    assign rf_we    = wb_valid & wb.gr_we;
    assign rf_waddr = wb.dest;
    assign rf_wdata = wb.wdata;

    assign wb_dst = '{valid: wb_valid, gr_we: wb.gr_we, is_load: 1'b0,
                      dest: wb.dest, fwd_data: wb.wdata};

    // writes to r0 still show up here
    assign trace = '{pc: wb.pc, rf_we: {4{rf_we}}, wnum: wb.dest, wdata: wb.wdata};

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    output imem_req_t            imem,
    input  logic [`CPU_XLEN-1:0] imem_rdata,
    output dmem_req_t            dmem,
    input  logic [`CPU_XLEN-1:0] dmem_rdata,
    output trace_t               trace
);

    if_id_t   f_to_id, id_q;
    id_exe_t  id_to_exe, exe_q;
    exe_mem_t exe_to_mem, mem_q;
    mem_wb_t  mem_to_wb, wb_q;
    logic     f_to_id_valid, id_valid, exe_valid, mem_valid, wb_valid;
    logic     stall, br_taken, src1_used, src2_used, rf_we;
    logic [`CPU_XLEN-1:0]   br_target, rf_rdata1, rf_rdata2, rf_wdata;
    logic [`CPU_REG_AW-1:0] rf_raddr1, rf_raddr2, rf_waddr;
    fwd_sel_e    fwd1, fwd2;
    stage_dest_t exe_dst, mem_dst, wb_dst;

    // later stages never hold back, only decode can refuse
    wire wb_allowin  = 1'b1;
    wire mem_allowin = ~mem_valid | wb_allowin;
    wire exe_allowin = ~exe_valid | mem_allowin;
    wire id_allowin  = ~id_valid | (~stall & exe_allowin);
    wire id_to_exe_valid = id_valid & ~stall;

    fetch_unit fetch_unit_inst (.clk, .reset, .stall, .br_taken, .br_target, .imem,
        .imem_rdata, .to_id_valid(f_to_id_valid), .to_id(f_to_id));

    stage_reg #(.payload_t(if_id_t)) if_id_reg (.clk, .reset, .allowin(id_allowin),
        .flush(br_taken), .in_valid(f_to_id_valid), .in_data(f_to_id),
        .out_valid(id_valid), .out_data(id_q));

    decode_unit decode_unit_inst (.id_valid, .id(id_q), .rf_raddr1, .rf_raddr2,
        .rf_rdata1, .rf_rdata2, .src1_used, .src2_used, .fwd1, .fwd2,
        .fwd_exe(exe_dst.fwd_data), .fwd_mem(mem_dst.fwd_data), .fwd_wb(wb_dst.fwd_data),
        .stall, .br_taken, .br_target, .to_exe(id_to_exe));

    reg_file reg_file_inst (.clk, .raddr1(rf_raddr1), .raddr2(rf_raddr2), .rdata1(rf_rdata1),
        .rdata2(rf_rdata2), .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata));

    hazard_unit hazard_unit_inst (.id_valid, .rs1(rf_raddr1), .rs2(rf_raddr2), .src1_used,
        .src2_used, .exe_dst, .mem_dst, .wb_dst, .fwd1, .fwd2, .stall);

    stage_reg #(.payload_t(id_exe_t)) id_exe_reg (.clk, .reset, .allowin(exe_allowin),
        .flush(1'b0), .in_valid(id_to_exe_valid), .in_data(id_to_exe),
        .out_valid(exe_valid), .out_data(exe_q));

    execute_unit execute_unit_inst (.exe_valid, .exe(exe_q), .dmem, .to_mem(exe_to_mem),
        .exe_dst);

    stage_reg #(.payload_t(exe_mem_t)) exe_mem_reg (.clk, .reset, .allowin(mem_allowin),
        .flush(1'b0), .in_valid(exe_valid), .in_data(exe_to_mem),
        .out_valid(mem_valid), .out_data(mem_q));

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (.clk, .reset, .allowin(wb_allowin),
        .flush(1'b0), .in_valid(mem_valid), .in_data(mem_to_wb),
        .out_valid(wb_valid), .out_data(wb_q));

    writeback_unit writeback_unit_inst (.mem_valid, .mem(mem_q), .dmem_rdata,
        .to_wb(mem_to_wb), .mem_dst, .wb_valid, .wb(wb_q), .rf_we, .rf_waddr, .rf_wdata,
        .wb_dst, .trace);

endmodule

// File: dv/cpu_properties.sv
`timescale 1ns/1ps

module cpu_properties
    import cpu_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input dmem_req_t dmem,
    input trace_t    trace
);

    // a write strobe needs a request behind it
    we_needs_en: assert property (
        @(posedge clk) disable iff (reset) (dmem.we != 4'h0) |-> dmem.en
    ) else $error("dmem write strobe raised without enable");

    // trace port writes whole words or nothing
    trace_we_whole: assert property (
        @(posedge clk) disable iff (reset) trace.rf_we inside {4'h0, 4'hf}
    ) else $error("trace rf_we holds partial value %b", trace.rf_we);

    // after a full reset cycle nothing may leave the core
    quiet_in_reset: assert property (
        @(posedge clk) reset ##1 reset |-> ((trace.rf_we == 4'h0) && !dmem.en)
    ) else $error("trace or dmem request active during reset");

endmodule

bind cpu_top cpu_properties cpu_properties_inst (
    .clk(clk),
    .reset(reset),
    .dmem(dmem),
    .trace(trace)
);

// File: dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
    import cpu_pkg::*;
();

    localparam logic [31:0] prog_base = 32'h1c00_0000;
    localparam logic [16:0] op_add = 17'h00020, op_sub = 17'h00022, op_slt = 17'h00024,
                            op_sltu = 17'h00025, op_nor = 17'h00028, op_and = 17'h00029,
                            op_or = 17'h0002a, op_xor = 17'h0002b;
    localparam logic [9:0]  op_addi = 10'h00a, op_ld = 10'h0a2, op_st = 10'h0a6;
    localparam logic [5:0]  op_b = 6'h14, op_bl = 6'h15, op_beq = 6'h16, op_bne = 6'h17;

    // one program slot with the write or store it should cause
    typedef struct packed {
        logic [31:0] inst;
        logic        traced;
        logic        stored;
        logic [4:0]  wnum;
        logic [31:0] value;
        logic [31:0] addr;
    } entry_t;

    logic        clk = 1'b0;
    logic        reset;
    imem_req_t   imem;
    logic [31:0] imem_rdata;
    dmem_req_t   dmem;
    logic [31:0] dmem_rdata;
    trace_t      trace;

    entry_t      prog [64];
    logic [31:0] ram [256];
    dmem_req_t   store_q [$];
    int          n_entries = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          trace_count = 0;
    int          check_count = 0;
    int          error_count = 0;

    cpu_top cpu_top_inst (.clk, .reset, .imem, .imem_rdata, .dmem, .dmem_rdata, .trace);

    always #5 clk = ~clk;

    function automatic logic [31:0] r3_word(input logic [16:0] op, input logic [4:0] rd,
                                            input logic [4:0] rj, input logic [4:0] rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] ri12_word(input logic [9:0] op, input logic [4:0] rd,
                                              input logic [4:0] rj, input logic [11:0] imm);
        return {op, imm, rj, rd};
    endfunction

    function automatic logic [31:0] lu12i_word(input logic [4:0] rd, input logic [19:0] imm);
        return {7'h0a, imm, rd};
    endfunction

    // offsets in bytes, word aligned
    function automatic logic [31:0] br16_word(input logic [5:0] op, input logic [4:0] rj,
                                              input logic [4:0] rd, input logic [17:0] offs);
        return {op, offs[17:2], rj, rd};
    endfunction

    function automatic logic [31:0] br26_word(input logic [5:0] op, input logic [27:0] offs);
        return {op, offs[17:2], offs[27:18]};
    endfunction

    function automatic logic [31:0] dmem_fill(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'h6b1d_e2a7;
    endfunction

    // unprogrammed words keep the top byte outside every kept opcode
    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - prog_base) >> 2;
        if (addr[1:0] == 2'b00 && idx < n_entries) begin
            return prog[idx].inst;
        end else begin
            return {8'h03, addr[23:0] ^ {3{addr[31:24]}}};
        end
    endfunction

    task automatic put_row(input logic [31:0] inst, input logic traced, input logic stored,
                           input logic [4:0] wnum, input logic [31:0] value,
                           input logic [31:0] addr);
        prog[n_entries] = '{inst, traced, stored, wnum, value, addr};
        n_entries++;
    endtask

    task automatic load_program();
        // dependent alu chain, forwarded from exe, mem and wb
        put_row(ri12_word(op_addi, 1, 0, 12'h123), 1, 0, 1, 32'h0000_0123, 0);
        put_row(lu12i_word(2, 20'h12345), 1, 0, 2, 32'h1234_5000, 0);
        put_row(r3_word(op_add, 3, 2, 1), 1, 0, 3, 32'h1234_5123, 0);
        put_row(r3_word(op_sub, 4, 3, 1), 1, 0, 4, 32'h1234_5000, 0);
        put_row(ri12_word(op_addi, 5, 0, 12'hfff), 1, 0, 5, 32'hffff_ffff, 0);
        put_row(r3_word(op_slt, 6, 5, 1), 1, 0, 6, 32'h0000_0001, 0);
        put_row(r3_word(op_sltu, 7, 5, 1), 1, 0, 7, 32'h0000_0000, 0);
        put_row(r3_word(op_nor, 8, 3, 1), 1, 0, 8, 32'hedcb_aedc, 0);
        put_row(r3_word(op_and, 9, 3, 4), 1, 0, 9, 32'h1234_5000, 0);
        put_row(r3_word(op_or, 10, 9, 1), 1, 0, 10, 32'h1234_5123, 0);
        put_row(r3_word(op_xor, 11, 10, 2), 1, 0, 11, 32'h0000_0123, 0);
        put_row(ri12_word(op_addi, 12, 0, 12'h100), 1, 0, 12, 32'h0000_0100, 0);
        // stores, then loads with their users right behind
        put_row(ri12_word(op_st, 3, 12, 12'h000), 0, 1, 0, 32'h1234_5123, 32'h100);
        put_row(ri12_word(op_st, 8, 12, 12'h004), 0, 1, 0, 32'hedcb_aedc, 32'h104);
        put_row(ri12_word(op_ld, 13, 12, 12'h000), 1, 0, 13, 32'h1234_5123, 0);
        put_row(r3_word(op_add, 14, 13, 1), 1, 0, 14, 32'h1234_5246, 0);
        put_row(ri12_word(op_ld, 15, 12, 12'h004), 1, 0, 15, 32'hedcb_aedc, 0);
        put_row(ri12_word(op_ld, 16, 12, 12'h008), 1, 0, 16, dmem_fill(32'h108), 0);
        put_row(r3_word(op_xor, 17, 16, 15), 1, 0, 17, dmem_fill(32'h108) ^ 32'hedcb_aedc, 0);
        // every taken branch hides the word after it
        put_row(br16_word(op_beq, 13, 3, 8), 0, 0, 0, 0, 0);
        put_row(ri12_word(op_addi, 18, 0, 12'h001), 0, 0, 0, 0, 0);
        put_row(br16_word(op_bne, 1, 11, 8), 0, 0, 0, 0, 0);
        put_row(br16_word(op_bne, 5, 0, 8), 0, 0, 0, 0, 0);
        put_row(ri12_word(op_addi, 19, 0, 12'h002), 0, 0, 0, 0, 0);
        put_row(br16_word(op_beq, 1, 2, 8), 0, 0, 0, 0, 0);
        put_row(br26_word(op_bl, 8), 1, 0, 1, 32'h1c00_0068, 0);
        put_row(ri12_word(op_addi, 20, 0, 12'h003), 0, 0, 0, 0, 0);
        put_row(ri12_word(op_addi, 21, 1, 12'h000), 1, 0, 21, 32'h1c00_0068, 0);
        put_row(br26_word(op_b, 8), 0, 0, 0, 0, 0);
        put_row(ri12_word(op_addi, 22, 0, 12'h004), 0, 0, 0, 0, 0);
        // r0 write shows in the trace, r0 still reads zero
        put_row(ri12_word(op_addi, 0, 0, 12'h005), 1, 0, 0, 32'h0000_0005, 0);
        put_row(r3_word(op_add, 23, 0, 0), 1, 0, 23, 32'h0000_0000, 0);
        put_row(ri12_word(op_st, 21, 12, 12'h00c), 0, 1, 0, 32'h1c00_0068, 32'h10c);
        put_row(ri12_word(op_ld, 24, 12, 12'h00c), 1, 0, 24, 32'h1c00_0068, 0);
        // park on a branch to itself
        put_row(br26_word(op_b, 0), 0, 0, 0, 0, 0);
    endtask

    task automatic check_trace(input trace_t got, input trace_t exp, output logic ok);
        ok = 1'b1;
        check_count++;
        if (got.pc !== exp.pc) begin
            $display("mismatch at %0t: trace.pc got %h expected %h", $time, got.pc, exp.pc);
            ok = 1'b0;
        end
        if (got.rf_we !== exp.rf_we) begin
            $display("mismatch at %0t: trace.rf_we got %b expected %b", $time, got.rf_we,
                     exp.rf_we);
            ok = 1'b0;
        end
        if (got.wnum !== exp.wnum) begin
            $display("mismatch at %0t: trace.wnum got %0d expected %0d", $time, got.wnum,
                     exp.wnum);
            ok = 1'b0;
        end
        if (got.wdata !== exp.wdata) begin
            $display("mismatch at %0t: trace.wdata got %h expected %h", $time, got.wdata,
                     exp.wdata);
            ok = 1'b0;
        end
        if (!ok) begin
            error_count++;
        end
    endtask

    task automatic check_dmem(input dmem_req_t got, input dmem_req_t exp, output logic ok);
        ok = 1'b1;
        check_count++;
        if (got.en !== exp.en || got.we !== exp.we) begin
            $display("mismatch at %0t: dmem.en/we got %b/%b expected %b/%b", $time, got.en,
                     got.we, exp.en, exp.we);
            ok = 1'b0;
        end
        if (got.addr !== exp.addr) begin
            $display("mismatch at %0t: dmem.addr got %h expected %h", $time, got.addr,
                     exp.addr);
            ok = 1'b0;
        end
        if (got.wdata !== exp.wdata) begin
            $display("mismatch at %0t: dmem.wdata got %h expected %h", $time, got.wdata,
                     exp.wdata);
            ok = 1'b0;
        end
        if (!ok) begin
            error_count++;
        end
    endtask

    task automatic check_quiet(input trace_t t, input dmem_req_t d, input imem_req_t f,
                               input logic [31:0] exp_addr);
        logic ok;
        ok = 1'b1;
        check_count++;
        if (t.rf_we !== 4'h0) begin
            $display("mismatch at %0t: trace.rf_we got %b expected 0000", $time, t.rf_we);
            ok = 1'b0;
        end
        if (d.en !== 1'b0) begin
            $display("mismatch at %0t: dmem.en got %b expected 0", $time, d.en);
            ok = 1'b0;
        end
        if (f.en !== 1'b1) begin
            $display("mismatch at %0t: imem.en got %b expected 1", $time, f.en);
            ok = 1'b0;
        end
        if (f.addr !== exp_addr) begin
            $display("mismatch at %0t: imem.addr got %h expected %h", $time, f.addr,
                     exp_addr);
            ok = 1'b0;
        end
        if (!ok) begin
            error_count++;
        end
        $display("idle check at %0t %s", $time, ok ? "ok" : "wrong");
    endtask

    task automatic wait_trace(output trace_t t);
        @(negedge clk);
        while (trace.rf_we == 4'h0) begin
            @(negedge clk);
        end
        t = trace;
    endtask

    // instruction sram, one-cycle read, holds its word while en is low
    always @(posedge clk) begin
        if (imem.en) begin
            imem_rdata <= rom_word(imem.addr);
        end
    end

    // data sram with byte strobes, read returns the old word
    always @(posedge clk) begin : dmem_model
        logic [31:0] word;
        int          b;
        if (dmem.en) begin
            word = ram[dmem.addr[9:2]];
            for (b = 0; b < 4; b++) begin
                if (dmem.we[b]) begin
                    word[8*b +: 8] = dmem.wdata[8*b +: 8];
                end
            end
            ram[dmem.addr[9:2]] <= word;
            dmem_rdata <= ram[dmem.addr[9:2]];
        end
    end

    always @(negedge clk) begin
        if (!reset && trace.rf_we != 4'h0) begin
            trace_count <= trace_count + 1;
        end
        if (!reset && dmem.we != 4'h0) begin
            store_q.push_back(dmem);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: program still running after %0d cycles", cycle_count);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        trace_t    got;
        trace_t    exp;
        dmem_req_t st_got;
        dmem_req_t st_exp;
        logic      ok;
        int        i;
        int        n_traced;
        reset = 1'b1;
        imem_rdata = '0;
        dmem_rdata = '0;
        n_traced = 0;
        load_program();
        for (i = 0; i < 256; i++) begin
            ram[i] = dmem_fill(i * 4);
        end
        cycle_limit = 4 * n_entries + 40;
        @(negedge clk);
        check_quiet(trace, dmem, imem, prog_base);
        @(posedge clk);
        reset <= 1'b0;
        // one sequential fetch per cycle from the first word
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_quiet(trace, dmem, imem, prog_base + (i << 2));
        end
        for (i = 0; i < n_entries; i++) begin
            if (prog[i].traced) begin
                n_traced++;
                wait_trace(got);
                exp.pc    = prog_base + (i << 2);
                exp.rf_we = 4'hf;
                exp.wnum  = prog[i].wnum;
                exp.wdata = prog[i].value;
                check_trace(got, exp, ok);
                $display("entry %0d pc %h r%0d = %h %s", i, exp.pc, exp.wnum, exp.wdata,
                         ok ? "ok" : "wrong");
            end else begin
                $display("entry %0d pc %h no register write expected", i, prog_base + (i << 2));
            end
        end
        // core now spins on its last branch, nothing else may retire
        repeat (8) @(negedge clk);
        if (trace_count != n_traced) begin
            $display("trace showed %0d writes where %0d were expected", trace_count, n_traced);
            error_count++;
        end
        for (i = 0; i < n_entries; i++) begin
            if (prog[i].stored) begin
                if (store_q.size() == 0) begin
                    $display("entry %0d store never reached the data sram", i);
                    error_count++;
                end else begin
                    st_got       = store_q.pop_front();
                    st_exp.en    = 1'b1;
                    st_exp.we    = 4'hf;
                    st_exp.addr  = prog[i].addr;
                    st_exp.wdata = prog[i].value;
                    check_dmem(st_got, st_exp, ok);
                    $display("entry %0d store %h to %h %s", i, st_exp.wdata, st_exp.addr,
                             ok ? "ok" : "wrong");
                end
            end
        end
        if (store_q.size() != 0) begin
            $display("data sram saw %0d stores that the program does not make", store_q.size());
            error_count++;
        end
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/cpu_pkg.sv
hdl/stage_reg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/reg_file.sv
hdl/hazard_unit.sv
hdl/execute_unit.sv
hdl/writeback_unit.sv
hdl/cpu_top.sv
dv/cpu_properties.sv
dv/cpu_tb.sv
